// File: common/eth_pkg.sv
// Shared constants of the two-channel streaming loop
// Packed types for the control word, the per-channel control and the stream beat
package eth_pkg;

    // Design dimensions, the top level overrides the channel and link values
    localparam int CHANNELS       = 2;
    localparam int FRAME_BEATS    = 2;
    localparam int SEND_GAP       = 4;
    localparam int LINK_DEPTH     = 4;

    // Message and counter widths, the LED byte is the id bit above the sequence
    localparam int MSG_W          = 8;
    localparam int SEQ_W          = 7;
    localparam int COUNT_W        = 16;

    // Control distribution and reset timing
    localparam int SYNC_STAGES    = 2;
    localparam int PIPE_STAGES    = 3;
    localparam int POWERUP_CYCLES = 16;
    localparam int PLL_COUNT      = 3;

    // Control word as it arrives with the valid strobe
    typedef struct packed {
        logic                enable;
        logic [CHANNELS-1:0] id;
        logic                reset_req;
    } stim_t;

    // Control as seen by one channel
    typedef struct packed {
        logic enable;
        logic id;
    } chan_ctl_t;

    // One beat on the link between sender and receiver
    typedef struct packed {
        logic             sop;
        logic             eop;
        logic             id;
        logic [SEQ_W-1:0] seq;
    } beat_t;

endpackage

// File: source/reset_sequencer.sv
// Design reset generation
// Power-up pipe, combination of reset sources and a two-stage per-channel fanout
module reset_sequencer #(
    parameter int CHANNELS = eth_pkg::CHANNELS
) (
    input  logic                          i_eth_clk,
    input  logic                          i_resetn,
    input  logic [eth_pkg::PLL_COUNT-1:0] i_pll_lock,
    input  logic                          i_reset_req,
    output logic                          o_resetn,
    output logic [CHANNELS-1:0]           o_chan_resetn
);
    // There is no board reset at power-up, so ones shift in from a cleared pipe
    logic [eth_pkg::POWERUP_CYCLES-1:0] powerup_pipe = '0;
    logic                               resetn_q;
    logic [CHANNELS-1:0]                fan1;
    logic [CHANNELS-1:0]                fan2;

    always_ff @(posedge i_eth_clk) begin
        powerup_pipe <= {powerup_pipe[eth_pkg::POWERUP_CYCLES-2:0], 1'b1};
    end

    // Any source held low keeps the design in reset, a request lasts one cycle
    always_ff @(posedge i_eth_clk) begin
        resetn_q <= powerup_pipe[eth_pkg::POWERUP_CYCLES-1] & (&i_pll_lock)
                    & i_resetn & ~i_reset_req;
    end

    // Two register stages give each channel its own reset copy
    always_ff @(posedge i_eth_clk) begin
        fan1 <= {CHANNELS{resetn_q}};
        fan2 <= fan1;
    end

    assign o_resetn      = resetn_q;
    assign o_chan_resetn = fan2;

endmodule

// File: control/stim_capture.sv
// Control stimulus capture on the valid strobe
// Per-channel synchronizer and distribution pipeline for enable and id
module stim_capture #(
    parameter int CHANNELS = eth_pkg::CHANNELS
) (
    input  logic                               i_eth_clk,
    input  logic                               i_resetn,
    input  eth_pkg::stim_t                     i_stim,
    input  logic                               i_stim_valid,
    output logic                               o_reset_req,
    output eth_pkg::chan_ctl_t [CHANNELS-1:0]  o_ctl
);
    eth_pkg::chan_ctl_t [CHANNELS-1:0] captured;
    eth_pkg::chan_ctl_t [CHANNELS-1:0] sync_q [eth_pkg::SYNC_STAGES];
    eth_pkg::chan_ctl_t [CHANNELS-1:0] pipe_q [eth_pkg::PIPE_STAGES];

    // The request goes straight out so the resulting reset also clears this block
    assign o_reset_req = i_stim_valid & i_stim.reset_req;

    // Values hold between strobes, every channel shares enable but has its own id
    always_ff @(posedge i_eth_clk) begin
        if (!i_resetn) begin
            captured <= '0;
        end else if (i_stim_valid) begin
            for (int ch = 0; ch < CHANNELS; ch++) begin
                captured[ch].enable <= i_stim.enable;
                captured[ch].id     <= i_stim.id[ch];
            end
        end
    end

    // Synchronizer flops first, then the pipeline that reaches the channels
    // A strobe in cycle N shows at the output in cycle N+6
    always_ff @(posedge i_eth_clk) begin
        if (!i_resetn) begin
            sync_q <= '{default: '0};
            pipe_q <= '{default: '0};
        end else begin
            sync_q[0] <= captured;
            for (int s = 1; s < eth_pkg::SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
            pipe_q[0] <= sync_q[eth_pkg::SYNC_STAGES-1];
            for (int p = 1; p < eth_pkg::PIPE_STAGES; p++) begin
                pipe_q[p] <= pipe_q[p-1];
            end
        end
    end

    assign o_ctl = pipe_q[eth_pkg::PIPE_STAGES-1];

endmodule

// File: channel/frame_sender.sv
// Periodic frame generator for one channel
// Gap, beat, credit and sequence counters, beats are sent only against credits
module frame_sender #(
    parameter int FRAME_BEATS = eth_pkg::FRAME_BEATS,
    parameter int SEND_GAP    = eth_pkg::SEND_GAP,
    parameter int LINK_DEPTH  = eth_pkg::LINK_DEPTH
) (
    input  logic               i_eth_clk,
    input  logic               i_resetn,
    input  eth_pkg::chan_ctl_t i_ctl,
    input  logic               i_credit,
    output eth_pkg::beat_t     o_beat,
    output logic               o_beat_valid
);
    localparam int GAP_W  = $clog2(SEND_GAP + 1);
    localparam int BEAT_W = $clog2(FRAME_BEATS + 1);
    localparam int CRED_W = $clog2(LINK_DEPTH + 1);

    logic                      in_frame;
    logic [GAP_W-1:0]          gap_cnt;
    logic [BEAT_W-1:0]         beat_cnt;
    logic [CRED_W-1:0]         credits;
    logic [eth_pkg::SEQ_W-1:0] seq_num;
    logic                      frame_id;
    logic                      last_beat;

    // A beat leaves in every frame cycle that has a credit, otherwise the frame stalls
    assign o_beat_valid = in_frame && (credits != '0);
    assign last_beat    = beat_cnt == BEAT_W'(FRAME_BEATS - 1);
    assign o_beat.sop   = beat_cnt == '0;
    assign o_beat.eop   = last_beat;
    assign o_beat.id    = frame_id;
    assign o_beat.seq   = seq_num;

    // Idle gap while enabled, then one frame; a frame always runs to its end
    always_ff @(posedge i_eth_clk) begin
        if (!i_resetn) begin
            in_frame <= 1'b0;
            gap_cnt  <= '0;
            beat_cnt <= '0;
            seq_num  <= '0;
        end else if (in_frame) begin
            if (o_beat_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    in_frame <= 1'b0;
                    beat_cnt <= '0;
                    seq_num  <= seq_num + 1'b1;
                end
            end
        end else if (i_ctl.enable) begin
            if (gap_cnt == GAP_W'(SEND_GAP - 1)) begin
                in_frame <= 1'b1;
                gap_cnt  <= '0;
            end else begin
                gap_cnt <= gap_cnt + 1'b1;
            end
        end else begin
            gap_cnt <= '0;
        end
    end

    // The id is frozen for the whole frame at its start
    always_ff @(posedge i_eth_clk) begin
        if (!in_frame && i_ctl.enable) begin
            frame_id <= i_ctl.id;
        end
    end

    // Credits start at the link depth, each sent beat costs one
    always_ff @(posedge i_eth_clk) begin
        if (!i_resetn) begin
            credits <= CRED_W'(LINK_DEPTH);
        end else begin
            credits <= credits - CRED_W'(o_beat_valid) + CRED_W'(i_credit);
        end
    end

    // A credit only comes back for a beat in the link, so the count is below the depth then
    a_credit_bound: assert property (@(posedge i_eth_clk) disable iff (!i_resetn)
        i_credit |-> credits != CRED_W'(LINK_DEPTH))
        else $error("Credit returned while the credit count is already full");

endmodule

// File: channel/credit_link.sv
// Credit-controlled beat buffer standing in for the network access point
// Circular buffer of beats, one credit goes back per beat drained
module credit_link #(
    parameter int LINK_DEPTH = eth_pkg::LINK_DEPTH
) (
    input  logic           i_eth_clk,
    input  logic           i_resetn,
    input  eth_pkg::beat_t i_beat,
    input  logic           i_beat_valid,
    input  logic           i_pop,
    output eth_pkg::beat_t o_beat,
    output logic           o_beat_valid,
    output logic           o_credit
);
    localparam int PTR_W = $clog2(LINK_DEPTH);
    localparam int CNT_W = $clog2(LINK_DEPTH + 1);

    eth_pkg::beat_t   mem [LINK_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             full;
    logic             wr_ok;
    logic             pop_ok;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(LINK_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full         = fill == CNT_W'(LINK_DEPTH);
    assign wr_ok        = i_beat_valid && !full;
    assign o_beat_valid = fill != '0;
    assign o_beat       = mem[rd_ptr];
    assign pop_ok       = i_pop && o_beat_valid;

    // A written beat is visible on the read side one cycle later
    always_ff @(posedge i_eth_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_beat;
        end
    end

    always_ff @(posedge i_eth_clk) begin
        if (!i_resetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            o_credit <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            fill     <= fill + CNT_W'(wr_ok) - CNT_W'(pop_ok);
            // Credit pulse for every drained beat
            o_credit <= pop_ok;
        end
    end

    // The sender's credit count must keep it from writing into a full buffer
    a_no_overflow: assert property (@(posedge i_eth_clk) disable iff (!i_resetn)
        i_beat_valid |-> !full)
        else $error("Write into full link buffer");

endmodule

// File: channel/frame_receiver.sv
// Frame checker for one channel
// Structure check with sticky error, frame counter and LED message register
module frame_receiver (
    input  logic                        i_eth_clk,
    input  logic                        i_resetn,
    input  eth_pkg::beat_t              i_beat,
    input  logic                        i_beat_valid,
    input  logic                        i_rx_hold,
    output logic                        o_pop,
    output logic [eth_pkg::MSG_W-1:0]   o_led_byte,
    output logic [eth_pkg::COUNT_W-1:0] o_frame_count,
    output logic                        o_error
);
    logic in_frame;

    // Hold blocks every pop, the link then fills and credits stop flowing
    assign o_pop = i_beat_valid && !i_rx_hold;

    always_ff @(posedge i_eth_clk) begin
        if (!i_resetn) begin
            in_frame      <= 1'b0;
            o_led_byte    <= '0;
            o_frame_count <= '0;
            o_error       <= 1'b0;
        end else if (o_pop) begin
            // A sop inside a frame or a missing sop outside one is a framing error
            if (i_beat.sop == in_frame) begin
                o_error <= 1'b1;
            end
            in_frame <= !i_beat.eop;
            // End of frame loads the message and counts the frame
            if (i_beat.eop) begin
                o_led_byte    <= eth_pkg::MSG_W'({i_beat.id, i_beat.seq});
                o_frame_count <= o_frame_count + 1'b1;
            end
        end
    end

endmodule

// File: channel/eth_channel.sv
// One streaming channel
// Frame sender, credit link and frame receiver with a local credit loop
module eth_channel #(
    parameter int FRAME_BEATS = eth_pkg::FRAME_BEATS,
    parameter int SEND_GAP    = eth_pkg::SEND_GAP,
    parameter int LINK_DEPTH  = eth_pkg::LINK_DEPTH
) (
    input  logic                        i_eth_clk,
    input  logic                        i_resetn,
    input  eth_pkg::chan_ctl_t          i_ctl,
    input  logic                        i_rx_hold,
    output logic [eth_pkg::MSG_W-1:0]   o_led_byte,
    output logic [eth_pkg::COUNT_W-1:0] o_frame_count,
    output logic                        o_error
);
    eth_pkg::beat_t tx_beat;
    logic           tx_valid;
    eth_pkg::beat_t rx_beat;
    logic           rx_valid;
    logic           pop;
    logic           credit;

    frame_sender #(
        .FRAME_BEATS (FRAME_BEATS),
        .SEND_GAP    (SEND_GAP),
        .LINK_DEPTH  (LINK_DEPTH)
    ) u_sender (
        .i_eth_clk    (i_eth_clk),
        .i_resetn     (i_resetn),
        .i_ctl        (i_ctl),
        .i_credit     (credit),
        .o_beat       (tx_beat),
        .o_beat_valid (tx_valid)
    );

    credit_link #(
        .LINK_DEPTH (LINK_DEPTH)
    ) u_link (
        .i_eth_clk    (i_eth_clk),
        .i_resetn     (i_resetn),
        .i_beat       (tx_beat),
        .i_beat_valid (tx_valid),
        .i_pop        (pop),
        .o_beat       (rx_beat),
        .o_beat_valid (rx_valid),
        .o_credit     (credit)
    );

    frame_receiver u_receiver (
        .i_eth_clk     (i_eth_clk),
        .i_resetn      (i_resetn),
        .i_beat        (rx_beat),
        .i_beat_valid  (rx_valid),
        .i_rx_hold     (i_rx_hold),
        .o_pop         (pop),
        .o_led_byte    (o_led_byte),
        .o_frame_count (o_frame_count),
        .o_error       (o_error)
    );

endmodule

// File: source/led_driver.sv
// LED output stage
// Registered XOR of the channel LED bytes and a sticky merge of channel errors
module led_driver #(
    parameter int CHANNELS = eth_pkg::CHANNELS
) (
    input  logic                                    i_eth_clk,
    input  logic                                    i_resetn,
    input  logic [CHANNELS-1:0][eth_pkg::MSG_W-1:0] i_led_bytes,
    input  logic [CHANNELS-1:0]                     i_errors,
    output logic [eth_pkg::MSG_W-1:0]               o_led,
    output logic                                    o_error
);
    logic [eth_pkg::MSG_W-1:0] led_mix;

    // Equal bytes cancel, so only differences between channels light up
    always_comb begin
        led_mix = '0;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            led_mix = led_mix ^ i_led_bytes[ch];
        end
    end

    always_ff @(posedge i_eth_clk) begin
        if (!i_resetn) begin
            o_led   <= '0;
            o_error <= 1'b0;
        end else begin
            o_led   <= led_mix;
            o_error <= o_error | (|i_errors);
        end
    end

endmodule

// File: source/eth_loopback_top.sv
// Top level of the two-channel streaming loop
// Reset sequencer, stimulus capture, channel array and LED driver
module eth_loopback_top #(
    parameter int CHANNELS    = eth_pkg::CHANNELS,
    parameter int FRAME_BEATS = eth_pkg::FRAME_BEATS,
    parameter int SEND_GAP    = eth_pkg::SEND_GAP,
    parameter int LINK_DEPTH  = eth_pkg::LINK_DEPTH
) (
    input  logic                                      i_eth_clk,
    input  logic                                      i_resetn,
    input  logic [eth_pkg::PLL_COUNT-1:0]             i_pll_lock,
    input  eth_pkg::stim_t                            i_stim,
    input  logic                                      i_stim_valid,
    input  logic                                      i_rx_hold,
    output logic [eth_pkg::MSG_W-1:0]                 o_led,
    output logic [CHANNELS-1:0][eth_pkg::COUNT_W-1:0] o_frame_count,
    output logic                                      o_error
);
    logic                                  resetn;
    logic [CHANNELS-1:0]                   chan_resetn;
    logic                                  reset_req;
    eth_pkg::chan_ctl_t [CHANNELS-1:0]     chan_ctl;
    logic [CHANNELS-1:0][eth_pkg::MSG_W-1:0] led_bytes;
    logic [CHANNELS-1:0]                   chan_errors;

    // ------------------------------------------------------------------------
    // Reset and control distribution
    // ------------------------------------------------------------------------
    reset_sequencer #(
        .CHANNELS (CHANNELS)
    ) u_reset_seq (
        .i_eth_clk     (i_eth_clk),
        .i_resetn      (i_resetn),
        .i_pll_lock    (i_pll_lock),
        .i_reset_req   (reset_req),
        .o_resetn      (resetn),
        .o_chan_resetn (chan_resetn)
    );

    stim_capture #(
        .CHANNELS (CHANNELS)
    ) u_stim_capture (
        .i_eth_clk    (i_eth_clk),
        .i_resetn     (resetn),
        .i_stim       (i_stim),
        .i_stim_valid (i_stim_valid),
        .o_reset_req  (reset_req),
        .o_ctl        (chan_ctl)
    );

    // ------------------------------------------------------------------------
    // Channels, each with its own reset copy and credit loop
    // ------------------------------------------------------------------------
    for (genvar g = 0; g < CHANNELS; g++) begin : g_chan
        eth_channel #(
            .FRAME_BEATS (FRAME_BEATS),
            .SEND_GAP    (SEND_GAP),
            .LINK_DEPTH  (LINK_DEPTH)
        ) u_channel (
            .i_eth_clk     (i_eth_clk),
            .i_resetn      (chan_resetn[g]),
            .i_ctl         (chan_ctl[g]),
            .i_rx_hold     (i_rx_hold),
            .o_led_byte    (led_bytes[g]),
            .o_frame_count (o_frame_count[g]),
            .o_error       (chan_errors[g])
        );
    end

    led_driver #(
        .CHANNELS (CHANNELS)
    ) u_led_driver (
        .i_eth_clk   (i_eth_clk),
        .i_resetn    (resetn),
        .i_led_bytes (led_bytes),
        .i_errors    (chan_errors),
        .o_led       (o_led),
        .o_error     (o_error)
    );

endmodule

// File: sim/tb_eth_loopback.sv
// Testbench for the two-channel streaming loop
// Clock and reset generation, stimulus table applied in a loop, result checks,
// cycle-count timeout and the closing report
module tb_eth_loopback;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS     = 5;
    localparam int STABLE_CYCLES = 40;
    localparam int TEST_SLACK    = 200;

    // How a test entry is judged once the counts have settled
    localparam logic [1:0] CHECK_ZERO = 2'd0;
    localparam logic [1:0] CHECK_RUN  = 2'd1;

    // One row of the stimulus table
    typedef struct packed {
        logic                      apply_stim;
        eth_pkg::stim_t            stim;
        logic                      rx_hold;
        int                        run_cycles;
        logic [1:0]                check_kind;
        logic [eth_pkg::MSG_W-1:0] exp_led;
    } test_entry_t;

    logic                                                     i_eth_clk;
    logic                                                     i_resetn;
    logic [eth_pkg::PLL_COUNT-1:0]                            i_pll_lock;
    eth_pkg::stim_t                                           i_stim;
    logic                                                     i_stim_valid;
    logic                                                     i_rx_hold;
    logic [eth_pkg::MSG_W-1:0]                                o_led;
    logic [eth_pkg::CHANNELS-1:0][eth_pkg::COUNT_W-1:0]       frame_count;
    logic                                                     o_error;

    test_entry_t                                        tests [NUM_TESTS];
    string                                              test_names [NUM_TESTS];
    string                                              cur_name;
    int                                                 error_count = 0;
    int                                                 test_errors = 0;
    int                                                 failed_tests = 0;
    int                                                 timeout_limit = 0;
    int                                                 cycle_count = 0;
    logic [eth_pkg::CHANNELS-1:0][eth_pkg::COUNT_W-1:0] prev_count;
    logic                                               hold_violation;

    eth_loopback_top #(
        .CHANNELS    (eth_pkg::CHANNELS),
        .FRAME_BEATS (eth_pkg::FRAME_BEATS),
        .SEND_GAP    (eth_pkg::SEND_GAP),
        .LINK_DEPTH  (eth_pkg::LINK_DEPTH)
    ) dut0 (
        .i_eth_clk     (i_eth_clk),
        .i_resetn      (i_resetn),
        .i_pll_lock    (i_pll_lock),
        .i_stim        (i_stim),
        .i_stim_valid  (i_stim_valid),
        .i_rx_hold     (i_rx_hold),
        .o_led         (o_led),
        .o_frame_count (frame_count),
        .o_error       (o_error)
    );

    // 100 ns clock period
    initial begin
        i_eth_clk = 1'b0;
        forever #50 i_eth_clk = ~i_eth_clk;
    end

    // -------------------------------------------------------------------------
    // Helpers
    // -------------------------------------------------------------------------

    function automatic eth_pkg::stim_t make_stim(input logic enable,
                                                 input logic [eth_pkg::CHANNELS-1:0] id,
                                                 input logic reset_req);
        eth_pkg::stim_t s;
        s.enable    = enable;
        s.id        = id;
        s.reset_req = reset_req;
        return s;
    endfunction

    task automatic set_test(input int idx, input string name, input logic apply,
                            input eth_pkg::stim_t stim, input logic hold, input int run,
                            input logic [1:0] kind, input logic [eth_pkg::MSG_W-1:0] led);
        test_names[idx]       = name;
        tests[idx].apply_stim = apply;
        tests[idx].stim       = stim;
        tests[idx].rx_hold    = hold;
        tests[idx].run_cycles = run;
        tests[idx].check_kind = kind;
        tests[idx].exp_led    = led;
    endtask

    // Every test may use its run length plus a fixed margin for strobes and settling
    function automatic int run_length_limit();
        int total;
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += tests[t].run_cycles + TEST_SLACK;
        end
        return total;
    endfunction

    // Inputs change and outputs are read 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge i_eth_clk);
        #1;
    endtask

    // One-cycle valid strobe carrying a control word
    task automatic send_stim(input eth_pkg::stim_t s);
        i_stim       = s;
        i_stim_valid = 1'b1;
        next_cycle();
        i_stim_valid = 1'b0;
    endtask

    // Frame latency varies, so the end of traffic is seen as counts that stop moving
    task automatic wait_counts_stable();
        logic [eth_pkg::CHANNELS-1:0][eth_pkg::COUNT_W-1:0] last;
        int                                                 stable;
        last   = frame_count;
        stable = 0;
        while (stable < STABLE_CYCLES) begin
            next_cycle();
            if (frame_count == last) begin
                stable++;
            end else begin
                stable = 0;
                last   = frame_count;
            end
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("error %s: %s expected 0x%0h, actual 0x%0h",
                     cur_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("test %s went wrong: %s", cur_name, what);
            test_errors++;
        end
    endtask

    // -------------------------------------------------------------------------
    // Watchdog, ends a stuck run after the table's total budget
    // -------------------------------------------------------------------------
    initial begin
        @(posedge i_eth_clk);
        while (cycle_count < timeout_limit) begin
            @(posedge i_eth_clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("Errors found");
        $finish;
    end

    // -------------------------------------------------------------------------
    // Stimulus table and test sequence
    // -------------------------------------------------------------------------
    initial begin
        i_resetn     = 1'b0;
        i_pll_lock   = '1;
        i_stim       = '0;
        i_stim_valid = 1'b0;
        i_rx_hold    = 1'b0;

        // Channel 0 takes id bit 0, so 2'b01 gives channel 0 the id 1
        set_test(0, "reset_state", 1'b0, make_stim(1'b0, 2'b00, 1'b0), 1'b0, 0,
                 CHECK_ZERO, 8'h00);
        set_test(1, "same_ids", 1'b1, make_stim(1'b1, 2'b00, 1'b0), 1'b0, 80,
                 CHECK_RUN, 8'h00);
        set_test(2, "different_ids", 1'b1, make_stim(1'b1, 2'b01, 1'b0), 1'b0, 80,
                 CHECK_RUN, 8'h80);
        // Channel 1 carries the id here, so the LEDs stay lit until the reset request
        set_test(3, "back_pressure", 1'b1, make_stim(1'b1, 2'b10, 1'b0), 1'b1, 60,
                 CHECK_RUN, 8'h80);
        set_test(4, "reset_request", 1'b1, make_stim(1'b0, 2'b00, 1'b1), 1'b0, 0,
                 CHECK_ZERO, 8'h00);
        timeout_limit = run_length_limit();

        // External reset for 10 cycles, the power-up pipe then releases the design
        repeat (10) @(posedge i_eth_clk);
        #1;
        i_resetn = 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_name       = test_names[t];
            test_errors    = 0;
            hold_violation = 1'b0;
            prev_count     = frame_count;

            if (tests[t].apply_stim) begin
                i_rx_hold = tests[t].rx_hold;
                send_stim(tests[t].stim);
            end

            // While hold is high no beat is popped, so no frame may complete
            for (int c = 0; c < tests[t].run_cycles; c++) begin
                next_cycle();
                if (i_rx_hold && frame_count != prev_count) begin
                    hold_violation = 1'b1;
                end
            end
            if (tests[t].rx_hold) begin
                check_true(!hold_violation, "a frame count changed while rx_hold was high");
                i_rx_hold = 1'b0;
            end

            // Senders finish their current frame after enable falls
            if (tests[t].stim.enable) begin
                send_stim(make_stim(1'b0, tests[t].stim.id, 1'b0));
            end
            wait_counts_stable();

            if (tests[t].check_kind == CHECK_ZERO) begin
                check_value("o_led", 32'h0, 32'(o_led));
                for (int ch = 0; ch < eth_pkg::CHANNELS; ch++) begin
                    check_value($sformatf("frame count of channel %0d", ch), 32'h0,
                                32'(frame_count[ch]));
                end
                check_value("o_error", 32'h0, 32'(o_error));
            end else begin
                // Both channels run in lockstep, so their counts and sequences match
                check_true(frame_count[0] > prev_count[0],
                           "the frame count of channel 0 did not increase");
                check_value("frame count of channel 1", 32'(frame_count[0]),
                            32'(frame_count[1]));
                check_value("o_led", 32'(tests[t].exp_led), 32'(o_led));
                check_value("o_error", 32'h0, 32'(o_error));
            end

            if (test_errors == 0) begin
                $display("test %-14s passed", cur_name);
            end else begin
                $display("test %-14s failed with %0d failed checks", cur_name, test_errors);
                failed_tests++;
                error_count += test_errors;
            end
        end

        $display("tests %0d, failed tests %0d, failed checks %0d",
                 NUM_TESTS, failed_tests, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: verilog.f
common/eth_pkg.sv
source/reset_sequencer.sv
control/stim_capture.sv
channel/frame_sender.sv
channel/credit_link.sv
channel/frame_receiver.sv
channel/eth_channel.sv
source/led_driver.sv
source/eth_loopback_top.sv
sim/tb_eth_loopback.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the streaming loop testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_eth_loopback -Mdir obj_dir -f verilog.f
./obj_dir/Vtb_eth_loopback | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
